// File: common/des_pkg.sv
`default_nettype none

package des_pkg;

    localparam int N_ROUNDS = 16;          // Pipeline depth, one stage per round

    typedef logic [63:0] block_t;          // Plaintext or ciphertext block
    typedef logic [31:0] half_t;           // L or R half
    typedef logic [47:0] subkey_t;         // Round key after PC-2
    typedef logic [63:0] key_t;            // Full key, parity bits included
    typedef logic [7:0]  apb_addr_t;       // APB byte address

    // Index i holds the subkey of round i+1
    typedef subkey_t [N_ROUNDS-1:0] subkeys_t;

    // APB register map
    localparam apb_addr_t ADDR_KEY_HI  = 8'h00;
    localparam apb_addr_t ADDR_KEY_LO  = 8'h04;
    localparam apb_addr_t ADDR_DATA_HI = 8'h08;
    localparam apb_addr_t ADDR_DATA_LO = 8'h0C;  // Write launches the block
    localparam apb_addr_t ADDR_STATUS  = 8'h10;
    localparam apb_addr_t ADDR_RES_HI  = 8'h14;
    localparam apb_addr_t ADDR_RES_LO  = 8'h18;  // Read pops the entry

endpackage

`default_nettype wire

// File: des_round/des_sbox.sv
`timescale 1ns/100ps
`default_nettype none

module des_sbox (
    input  des_pkg::subkey_t din,   // E(R) xor K
    output des_pkg::half_t   dout   // Eight 4-bit outputs, S1 in the top nibble
);

    // One 64-bit word per table row, column 0 in the top nibble
    // Index is box*4 + row
    localparam logic [63:0] SBOX_ROWS [32] = '{
        64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,    // S1
        64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D,
        64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,    // S2
        64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9,
        64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,    // S3
        64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C,
        64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,    // S4
        64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E,
        64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,    // S5
        64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453,
        64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,    // S6
        64'h9EF528C3704A1DB6, 64'h432C95FABE17608D,
        64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,    // S7
        64'h14BDC37EAF680592, 64'h6BD814A7950FE23C,
        64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,    // S8
        64'h7B419CE206ADF358, 64'h21E74A8DFC90356B
    };

    always_comb begin
        logic [5:0]  six;       // Input group of the current box
        logic [1:0]  row;
        logic [3:0]  col;
        logic [63:0] line;
        dout = '0;
        for (int b = 0; b < 8; b++) begin
            six  = din[47 - 6*b -: 6];
            row  = {six[5], six[0]};                // Outer bits pick the row
            col  = six[4:1];                        // Inner four pick the column
            line = SBOX_ROWS[4*b + int'(row)];
            dout[31 - 4*b -: 4] = line[63 - 4*int'(col) -: 4];
        end
    end

endmodule

`default_nettype wire

// File: des_round/des_round.sv
`timescale 1ns/100ps
`default_nettype none

module des_round (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  des_pkg::half_t    l_in,
    input  des_pkg::half_t    r_in,
    input  des_pkg::subkey_t  subkey,
    output logic              out_valid,
    output des_pkg::half_t    l_out,
    output des_pkg::half_t    r_out
);

    import des_pkg::*;

    // E expansion, DES bit numbers 1..32 counted from the MSB
    localparam int E_TBL [48] = '{
        32,  1,  2,  3,  4,  5,  4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32,  1
    };

    // P permutation on the S-box output
    localparam int P_TBL [32] = '{
        16,  7, 20, 21, 29, 12, 28, 17,  1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9, 19, 13, 30,  6, 22, 11,  4, 25
    };

    subkey_t e_out;
    half_t   s_out;
    half_t   p_out;
    half_t   s_reg;     // Stage register, S-box result
    half_t   r_reg;
    half_t   l_reg;

    always_comb begin
        for (int i = 0; i < 48; i++) e_out[47 - i] = r_in[32 - E_TBL[i]];
    end

    des_sbox i_sbox (
        .din  (e_out ^ subkey),     // Key mixing ahead of the tables
        .dout (s_out)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;  // Valid walks alongside the data
        end
    end

    always_ff @(posedge clk) begin
        s_reg <= s_out;
        r_reg <= r_in;
        l_reg <= l_in;
    end

    always_comb begin
        for (int i = 0; i < 32; i++) p_out[31 - i] = s_reg[32 - P_TBL[i]];
    end

    assign l_out = r_reg;           // Swap halves
    assign r_out = l_reg ^ p_out;   // f(R, K) folded into L

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

endmodule

`default_nettype wire

// File: hw/des_key_schedule.sv
`timescale 1ns/100ps
`default_nettype none

module des_key_schedule (
    input  des_pkg::key_t     key,
    output des_pkg::subkeys_t subkeys
);

    import des_pkg::*;

    // PC-1 drops the eight parity bits, DES bit numbers 1..64
    localparam int PC1_TBL [56] = '{
        57, 49, 41, 33, 25, 17,  9,  1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27, 19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,  7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29, 21, 13,  5, 28, 20, 12,  4
    };

    // PC-2 picks 48 of the 56 C/D bits
    localparam int PC2_TBL [48] = '{
        14, 17, 11, 24,  1,  5,  3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8, 16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // Left rotation per round
    localparam int SHIFTS [N_ROUNDS] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    always_comb begin
        logic [55:0] cd;
        logic [27:0] c;
        logic [27:0] d;
        subkeys = '0;
        for (int j = 0; j < 56; j++) cd[55 - j] = key[64 - PC1_TBL[j]];
        c = cd[55:28];
        d = cd[27:0];
        for (int i = 0; i < N_ROUNDS; i++) begin
            c  = (c << SHIFTS[i]) | (c >> (28 - SHIFTS[i]));   // Rotate left by 1 or 2
            d  = (d << SHIFTS[i]) | (d >> (28 - SHIFTS[i]));
            cd = {c, d};
            for (int j = 0; j < 48; j++) subkeys[i][47 - j] = cd[56 - PC2_TBL[j]];
        end
    end

endmodule

`default_nettype wire

// File: hw/des_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module des_pipeline (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              launch,
    input  des_pkg::block_t   pt_block,
    input  des_pkg::subkeys_t subkeys,
    output logic              ct_valid,
    output des_pkg::block_t   ct_block
);

    import des_pkg::*;

    // Initial permutation
    localparam int IP_TBL [64] = '{
        58, 50, 42, 34, 26, 18, 10,  2, 60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6, 64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1, 59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5, 63, 55, 47, 39, 31, 23, 15,  7
    };

    // Inverse of IP
    localparam int FP_TBL [64] = '{
        40,  8, 48, 16, 56, 24, 64, 32, 39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30, 37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28, 35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26, 33,  1, 41,  9, 49, 17, 57, 25
    };

    block_t ip_block;
    block_t pre_out;                   // R16 L16 after the final swap
    half_t  l_chain [N_ROUNDS+1];
    half_t  r_chain [N_ROUNDS+1];
    logic   v_chain [N_ROUNDS+1];

    always_comb begin
        for (int i = 0; i < 64; i++) ip_block[63 - i] = pt_block[64 - IP_TBL[i]];
    end

    assign l_chain[0] = ip_block[63:32];
    assign r_chain[0] = ip_block[31:0];
    assign v_chain[0] = launch;

    for (genvar i = 0; i < N_ROUNDS; i++) begin : g_round
        des_round i_round (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (v_chain[i]),
            .l_in      (l_chain[i]),
            .r_in      (r_chain[i]),
            .subkey    (subkeys[i]),     // Round i+1 key
            .out_valid (v_chain[i+1]),
            .l_out     (l_chain[i+1]),
            .r_out     (r_chain[i+1])
        );
    end

    assign pre_out = {r_chain[N_ROUNDS], l_chain[N_ROUNDS]};  // Undo the last swap

    always_comb begin
        for (int i = 0; i < 64; i++) ct_block[63 - i] = pre_out[64 - FP_TBL[i]];
    end

    assign ct_valid = v_chain[N_ROUNDS];

    // Fixed latency, one cycle per round
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        launch |-> ##N_ROUNDS ct_valid);

endmodule

`default_nettype wire

// File: hw/des_apb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module des_apb_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  des_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  des_pkg::block_t    res_head,    // Oldest ciphertext in the buffer
    input  logic               res_avail,
    input  logic               credit,
    input  logic               in_flight,
    output des_pkg::key_t      key,
    output des_pkg::block_t    pt_block,
    output logic               launch,
    output logic               pop
);

    import des_pkg::*;

    logic        wr_acc;                // Access phase of a write
    logic        rd_acc;                // Access phase of a read
    logic        key_sel;
    logic        key_err;
    logic        data_err;
    logic        res_err;
    logic [31:0] key_hi;
    logic [31:0] key_lo;
    logic [31:0] data_hi;
    logic [31:0] data_lo;

    assign wr_acc  = psel && penable && pwrite;
    assign rd_acc  = psel && penable && !pwrite;
    assign key_sel = (paddr == ADDR_KEY_HI) || (paddr == ADDR_KEY_LO);

    // Error cases, all flagged in the access phase
    assign key_err  = wr_acc && key_sel && in_flight;    // Key must stay put under traffic
    assign data_err = wr_acc && (paddr == ADDR_DATA_LO) && !credit;
    assign res_err  = rd_acc && (paddr == ADDR_RES_LO) && !res_avail;

    assign launch  = wr_acc && (paddr == ADDR_DATA_LO) && credit;
    assign pop     = rd_acc && (paddr == ADDR_RES_LO) && res_avail;
    assign pslverr = key_err || data_err || res_err;
    assign pready  = 1'b1;                               // No wait states

    always_ff @(posedge clk) begin
        if (wr_acc) begin
            case (paddr)
                ADDR_KEY_HI:  if (!in_flight) key_hi <= pwdata;
                ADDR_KEY_LO:  if (!in_flight) key_lo <= pwdata;
                ADDR_DATA_HI: data_hi <= pwdata;
                ADDR_DATA_LO: data_lo <= pwdata;         // Kept for read-back even if dropped
                default: ;
            endcase
        end
    end

    assign key = {key_hi, key_lo};
    // Low word comes straight off the bus during the launching write
    assign pt_block = {data_hi, launch ? pwdata : data_lo};

    always_comb begin
        case (paddr)
            ADDR_KEY_HI:  prdata = key_hi;
            ADDR_KEY_LO:  prdata = key_lo;
            ADDR_DATA_HI: prdata = data_hi;
            ADDR_DATA_LO: prdata = data_lo;
            ADDR_STATUS:  prdata = {29'd0, !credit, in_flight, res_avail};
            ADDR_RES_HI:  prdata = res_head[63:32];
            ADDR_RES_LO:  prdata = res_head[31:0];
            default:      prdata = 32'd0;
        endcase
    end

    a_launch_pop_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(launch && pop));

endmodule

`default_nettype wire

// File: hw/des_result_buf.sv
`timescale 1ns/100ps
`default_nettype none

module des_result_buf #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            launch,
    input  logic            ct_valid,
    input  des_pkg::block_t ct_block,
    input  logic            pop,
    output des_pkg::block_t res_head,
    output logic            res_avail,
    output logic            credit,
    output logic            in_flight
);

    import des_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    block_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;          // Entries stored
    logic [CNT_W-1:0]   outstanding;    // Launched and not yet popped

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;  // Wraps for any depth
    endfunction

    always_ff @(posedge clk) begin
        if (ct_valid) mem[wr_ptr] <= ct_block;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            outstanding <= '0;
        end else begin
            if (ct_valid) wr_ptr <= ptr_next(wr_ptr);
            if (pop)      rd_ptr <= ptr_next(rd_ptr);
            count       <= count + CNT_W'(ct_valid) - CNT_W'(pop);
            outstanding <= outstanding + CNT_W'(launch) - CNT_W'(pop);
        end
    end

    assign res_head  = mem[rd_ptr];
    assign res_avail = (count != '0);
    assign credit    = (outstanding < CNT_W'(FIFO_DEPTH));  // Room reserved per launch
    assign in_flight = (outstanding != count);              // Difference sits in the pipeline

    // Credit rule keeps a slot free for every block in the pipeline
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        ct_valid |-> (count < CNT_W'(FIFO_DEPTH)));
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (outstanding != '0));

endmodule

`default_nettype wire

// File: hw/des_core.sv
`timescale 1ns/100ps
`default_nettype none

module des_core #(
    parameter int FIFO_DEPTH = 4        // Result buffer entries
) (
    input  logic               clk,
    input  logic               rst_n,
    input  des_pkg::apb_addr_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr
);

    import des_pkg::*;

    key_t     key;
    subkeys_t subkeys;
    block_t   pt_block;
    block_t   ct_block;
    block_t   res_head;
    logic     launch;
    logic     pop;
    logic     ct_valid;
    logic     res_avail;
    logic     credit;
    logic     in_flight;

    des_apb_regs i_apb_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .res_head  (res_head),
        .res_avail (res_avail),
        .credit    (credit),
        .in_flight (in_flight),
        .key       (key),
        .pt_block  (pt_block),
        .launch    (launch),
        .pop       (pop)
    );

    des_key_schedule i_key_schedule (
        .key     (key),
        .subkeys (subkeys)
    );

    des_pipeline i_pipeline (
        .clk      (clk),
        .rst_n    (rst_n),
        .launch   (launch),
        .pt_block (pt_block),
        .subkeys  (subkeys),
        .ct_valid (ct_valid),
        .ct_block (ct_block)
    );

    des_result_buf #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_result_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .launch    (launch),
        .ct_valid  (ct_valid),
        .ct_block  (ct_block),
        .pop       (pop),
        .res_head  (res_head),
        .res_avail (res_avail),
        .credit    (credit),
        .in_flight (in_flight)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;                   // Low for the first two rising edges
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    always #20 clk = ~clk;              // 40 ns period

endmodule

`default_nettype wire

// File: testbench/tb_des_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_des_core;

    import des_pkg::*;

    localparam int          MAX_CYCLES = 2000;     // Far above the length of all five tests
    localparam logic [63:0] KEY_A      = 64'h133457799BBCDFF1;
    localparam logic [63:0] PT_A       = 64'h0123456789ABCDEF;
    localparam logic [63:0] CT_A       = 64'h85E813540F0AB405;
    localparam logic [63:0] CT_ZERO    = 64'h8CA64DE9C1B123A7;  // Zero key, zero block

    logic        clk;
    logic        rst_n;
    apb_addr_t   paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    int          value_errors = 0;
    int          protocol_errors = 0;
    int          cycles = 0;
    block_t      expected_q [$];       // Ciphertexts owed by the DUT, oldest first

    tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    des_core #(.FIFO_DEPTH(4)) i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // Bus rules that hold on every cycle
    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else begin
            protocol_errors++;
            $display("pready went low");
        end
    a_err_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        pslverr |-> (psel && penable))
        else begin
            protocol_errors++;
            $display("pslverr raised outside an access phase");
        end
    a_status_known: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && penable && !pwrite && paddr == ADDR_STATUS) |-> !$isunknown(prdata))
        else begin
            protocol_errors++;
            $display("status read returned unknown bits");
        end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            value_errors++;
            $display("error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic idle_gap();
        repeat ($urandom_range(2, 0)) @(posedge clk);   // 0 to 2 idle cycles
    endtask

    task automatic apb_write(input apb_addr_t addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        psel    <= 1'b1;               // Setup phase
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;               // Access phase
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        idle_gap();
    endtask

    task automatic apb_read(input apb_addr_t addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;                 // Mid-cycle, before the pop takes effect
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        idle_gap();
    endtask

    task automatic write_key(input string name, input logic [63:0] key, input logic exp_err);
        logic err;
        apb_write(ADDR_KEY_HI, key[63:32], err);
        check_value({name, "_key_hi_err"}, 64'(exp_err), 64'(err));
        apb_write(ADDR_KEY_LO, key[31:0], err);
        check_value({name, "_key_lo_err"}, 64'(exp_err), 64'(err));
    endtask

    // Queues the expected ciphertext only when the launch is accepted
    task automatic launch_block(input string name, input logic [63:0] pt,
                                input logic [63:0] ct, input logic exp_err);
        logic err;
        apb_write(ADDR_DATA_HI, pt[63:32], err);
        check_value({name, "_data_hi_err"}, 64'd0, 64'(err));
        apb_write(ADDR_DATA_LO, pt[31:0], err);
        check_value({name, "_launch_err"}, 64'(exp_err), 64'(err));
        if (!exp_err) expected_q.push_back(ct);
    endtask

    task automatic wait_result(input string name);
        logic [31:0] st;
        logic        err;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st[0] && polls < 100) begin
            apb_read(ADDR_STATUS, st, err);
            polls++;
        end
        if (!st[0]) begin
            protocol_errors++;
            $display("%s: result never became available", name);
        end
    endtask

    task automatic read_result(input string name);
        logic [31:0] hi;
        logic [31:0] lo;
        logic        err_hi;
        logic        err_lo;
        block_t      expected;
        wait_result(name);
        apb_read(ADDR_RES_HI, hi, err_hi);
        apb_read(ADDR_RES_LO, lo, err_lo);   // Pops the entry
        check_value({name, "_res_err"}, 64'd0, 64'(err_hi | err_lo));
        if (expected_q.size() == 0) begin
            protocol_errors++;
            $display("%s: read a result that was never launched", name);
        end else begin
            expected = expected_q.pop_front();
            check_value(name, expected, {hi, lo});
        end
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        void'($urandom(32'h4b8b));
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        wait (rst_n === 1'b1);

        // Reset state
        apb_read(ADDR_STATUS, rd, err);
        check_value("reset_pslverr", 64'd0, 64'(err));
        check_value("reset_status", 64'd0, 64'(rd));

        // Known answers
        write_key("kat_a", KEY_A, 1'b0);
        launch_block("kat_a", PT_A, CT_A, 1'b0);
        read_result("kat_a");
        write_key("kat_zero", 64'd0, 1'b0);
        launch_block("kat_zero", 64'd0, CT_ZERO, 1'b0);
        read_result("kat_zero");

        // Back to back, zero key is weak so its ciphertext encrypts back to zero
        for (int i = 0; i < 4; i++) begin
            launch_block("b2b", (i % 2) ? CT_ZERO : 64'd0, (i % 2) ? 64'd0 : CT_ZERO, 1'b0);
        end
        for (int i = 0; i < 4; i++) read_result("b2b");

        // Credit, four outstanding fills the buffer
        for (int i = 0; i < 4; i++) begin
            launch_block("credit", (i % 2) ? CT_ZERO : 64'd0, (i % 2) ? 64'd0 : CT_ZERO, 1'b0);
        end
        launch_block("credit_fifth", 64'd0, CT_ZERO, 1'b1);
        apb_read(ADDR_STATUS, rd, err);
        check_value("credit_status_bit2", 64'd1, 64'(rd[2]));
        read_result("credit");
        launch_block("credit_refill", CT_ZERO, 64'd0, 1'b0);
        for (int i = 0; i < 4; i++) read_result("credit");

        // Protocol errors
        write_key("proto", KEY_A, 1'b0);
        launch_block("proto", PT_A, CT_A, 1'b0);
        write_key("proto_busy", 64'd0, 1'b1);   // Refused, block keeps KEY_A
        read_result("proto");
        apb_read(ADDR_RES_LO, rd, err);
        check_value("empty_pop_err", 64'd1, 64'(err));
        apb_read(ADDR_STATUS, rd, err);
        check_value("final_status", 64'd0, 64'(rd));

        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: des_core.f
common/des_pkg.sv
des_round/des_sbox.sv
des_round/des_round.sv
hw/des_key_schedule.sv
hw/des_pipeline.sv
hw/des_apb_regs.sv
hw/des_result_buf.sv
hw/des_core.sv
testbench/tb_clk_gen.sv
testbench/tb_des_core.sv

// File: Makefile
SRCS := $(shell grep '\.sv$$' des_core.f)

obj_dir/Vtb_des_core: des_core.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_des_core -f des_core.f

run: obj_dir/Vtb_des_core
	@out=$$(./obj_dir/Vtb_des_core); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: run clean
